// ==== project.f ====
src/l1_axi_pkg.sv
src/l1_req_dispatch.sv
src/axi_read_seq.sv
src/axi_write_seq.sv
src/l1_axi_bridge.sv
tests/axi_mem_model.sv
tests/tb_l1_axi_bridge.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the bridge testbench with Verilator and runs it.
# The exit status is non-zero if the build fails or the testbench stops with $fatal.
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/100ps -f project.f \
    --top-module tb_l1_axi_bridge -o sim_tb &&
./obj_dir/sim_tb ||
{ echo "Bridge simulation did not pass"; exit 1; }

// ==== src/axi_read_seq.sv ====
/*
 * AR/R sequencer for a single-beat line read. Started by a go pulse,
 * reports the line and its fault flag on the cycle the R beat lands.
 */
`timescale 1ns/100ps
`default_nettype none

module axi_read_seq (
    input  wire                          i_clk,
    input  wire                          i_nrst,
    input  wire                          i_go,
    input  wire l1_axi_pkg::axi_addr_t   i_addr,
    input  wire                          i_ar_ready,
    input  wire                          i_r_valid,
    input  wire                          i_r_last,
    input  wire [l1_axi_pkg::LINE_BITS-1:0] i_r_data,
    input  wire [1:0]                    i_r_resp,
    output logic                         o_ar_valid,
    output l1_axi_pkg::axi_addr_t        o_ar,
    output logic                         o_r_ready,
    output l1_axi_pkg::rd_resp_t         o_rd_resp
);

    l1_axi_pkg::rd_state_e state_q;
    logic                  beat_done;

    // R is single beat, so valid comes with last
    assign beat_done = (state_q == l1_axi_pkg::rd_data) && i_r_valid && i_r_last;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state_q <= l1_axi_pkg::rd_idle;
        end else begin
            case (state_q)
                l1_axi_pkg::rd_idle: if (i_go) state_q <= l1_axi_pkg::rd_addr;
                l1_axi_pkg::rd_addr: if (i_ar_ready) state_q <= l1_axi_pkg::rd_data;
                l1_axi_pkg::rd_data: if (beat_done) state_q <= l1_axi_pkg::rd_idle;
                default:             state_q <= l1_axi_pkg::rd_idle;
            endcase
        end
    end

    assign o_ar_valid = (state_q == l1_axi_pkg::rd_addr);
    assign o_ar       = i_addr;   // Dispatcher keeps it stable until done
    assign o_r_ready  = (state_q == l1_axi_pkg::rd_data);

    always_comb begin
        o_rd_resp.valid = beat_done;
        o_rd_resp.data  = i_r_data;
        o_rd_resp.fault = i_r_resp[l1_axi_pkg::RESP_FAULT_BIT];
    end

endmodule

`default_nettype wire

// ==== src/axi_write_seq.sv ====
/*
 * AW/W/B sequencer for a single-beat line write. Address and data are
 * offered together. W is held alone if the slave takes the address first,
 * and the B response fault flag is reported back as a one-cycle pulse.
 */
`timescale 1ns/100ps
`default_nettype none

module axi_write_seq (
    input  wire                        i_clk,
    input  wire                        i_nrst,
    input  wire                        i_go,
    input  wire l1_axi_pkg::axi_addr_t i_addr,
    input  wire l1_axi_pkg::axi_wr_t   i_wdata,
    input  wire                        i_aw_ready,
    input  wire                        i_w_ready,
    input  wire                        i_b_valid,
    input  wire [1:0]                  i_b_resp,
    output logic                       o_aw_valid,
    output l1_axi_pkg::axi_addr_t      o_aw,
    output logic                       o_w_valid,
    output logic                       o_w_last,
    output l1_axi_pkg::axi_wr_t        o_w,
    output logic                       o_b_ready,
    output l1_axi_pkg::wr_resp_t       o_wr_resp
);

    l1_axi_pkg::wr_state_e state_q;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state_q <= l1_axi_pkg::wr_idle;
        end else begin
            case (state_q)
                l1_axi_pkg::wr_idle: begin
                    if (i_go) begin
                        state_q <= l1_axi_pkg::wr_addr;
                    end
                end
                l1_axi_pkg::wr_addr: begin
                    // Slave never takes W before AW
                    if (i_aw_ready) begin
                        state_q <= i_w_ready ? l1_axi_pkg::wr_resp : l1_axi_pkg::wr_data;
                    end
                end
                l1_axi_pkg::wr_data: begin
                    if (i_w_ready) begin
                        state_q <= l1_axi_pkg::wr_resp;
                    end
                end
                l1_axi_pkg::wr_resp: begin
                    if (i_b_valid) begin
                        state_q <= l1_axi_pkg::wr_idle;
                    end
                end
                default: state_q <= l1_axi_pkg::wr_idle;
            endcase
        end
    end

    assign o_aw_valid = (state_q == l1_axi_pkg::wr_addr);
    assign o_aw       = i_addr;
    assign o_w_valid  = (state_q == l1_axi_pkg::wr_addr) || (state_q == l1_axi_pkg::wr_data);
    assign o_w_last   = 1'b1;          // Lite-style slave, one beat per line
    assign o_w        = i_wdata;
    assign o_b_ready  = (state_q == l1_axi_pkg::wr_resp);

    always_comb begin
        o_wr_resp.valid = o_b_ready && i_b_valid;
        o_wr_resp.fault = i_b_resp[l1_axi_pkg::RESP_FAULT_BIT];
    end

endmodule

`default_nettype wire

// ==== src/l1_axi_bridge.sv ====
/*
 * Bridge between the L1 cache memory port and an AXI4 master port.
 * One line request in flight, served by a read or a write sequencer.
 */
`timescale 1ns/100ps
`default_nettype none

module l1_axi_bridge (
    input  wire                             i_clk,
    input  wire                             i_nrst,
    input  wire l1_axi_pkg::mem_req_t       i_req,
    output logic                            o_req_ready,
    output l1_axi_pkg::mem_resp_t           o_resp,
    output logic                            o_ar_valid,
    output l1_axi_pkg::axi_addr_t           o_ar,
    input  wire                             i_ar_ready,
    output logic                            o_r_ready,
    input  wire                             i_r_valid,
    input  wire                             i_r_last,
    input  wire [l1_axi_pkg::LINE_BITS-1:0] i_r_data,
    input  wire [1:0]                       i_r_resp,
    output logic                            o_aw_valid,
    output l1_axi_pkg::axi_addr_t           o_aw,
    input  wire                             i_aw_ready,
    output logic                            o_w_valid,
    output logic                            o_w_last,
    output l1_axi_pkg::axi_wr_t             o_w,
    input  wire                             i_w_ready,
    output logic                            o_b_ready,
    input  wire                             i_b_valid,
    input  wire [1:0]                       i_b_resp
);

    logic                  rd_go;
    logic                  wr_go;
    l1_axi_pkg::axi_addr_t req_addr;
    l1_axi_pkg::axi_wr_t   req_wdata;
    l1_axi_pkg::rd_resp_t  rd_resp;
    l1_axi_pkg::wr_resp_t  wr_resp;

    l1_req_dispatch dispatch_inst (
        .i_clk      (i_clk),
        .i_nrst     (i_nrst),
        .i_req      (i_req),
        .i_rd_resp  (rd_resp),
        .i_wr_resp  (wr_resp),
        .o_req_ready(o_req_ready),
        .o_rd_go    (rd_go),
        .o_wr_go    (wr_go),
        .o_addr     (req_addr),
        .o_wdata    (req_wdata),
        .o_resp     (o_resp)
    );

    axi_read_seq read_seq_inst (
        .i_clk     (i_clk),
        .i_nrst    (i_nrst),
        .i_go      (rd_go),
        .i_addr    (req_addr),
        .i_ar_ready(i_ar_ready),
        .i_r_valid (i_r_valid),
        .i_r_last  (i_r_last),
        .i_r_data  (i_r_data),
        .i_r_resp  (i_r_resp),
        .o_ar_valid(o_ar_valid),
        .o_ar      (o_ar),
        .o_r_ready (o_r_ready),
        .o_rd_resp (rd_resp)
    );

    axi_write_seq write_seq_inst (
        .i_clk     (i_clk),
        .i_nrst    (i_nrst),
        .i_go      (wr_go),
        .i_addr    (req_addr),
        .i_wdata   (req_wdata),
        .i_aw_ready(i_aw_ready),
        .i_w_ready (i_w_ready),
        .i_b_valid (i_b_valid),
        .i_b_resp  (i_b_resp),
        .o_aw_valid(o_aw_valid),
        .o_aw      (o_aw),
        .o_w_valid (o_w_valid),
        .o_w_last  (o_w_last),
        .o_w       (o_w),
        .o_b_ready (o_b_ready),
        .o_wr_resp (wr_resp)
    );

endmodule

`default_nettype wire

// ==== src/l1_axi_pkg.sv ====
/*
 * Shared widths, AXI attribute codes, bundles and FSM states for the
 * L1-cache to AXI4 bridge. RTL and testbench refer to it by scoped names.
 */
`default_nettype none

package l1_axi_pkg;

    localparam int ADDR_BITS      = 32;
    localparam int LINE_BITS      = 256;
    localparam int LINE_BYTES     = LINE_BITS / 8;    // One strobe bit per byte
    localparam logic [2:0] SIZE_LINE = 3'd5;          // 2**5 bytes per beat
    localparam logic [3:0] CACHE_WB_ALLOC = 4'b1111;  // Write-back, read and write allocate
    localparam logic [3:0] CACHE_DEVICE   = 4'b0000;  // Device, non-bufferable
    localparam int RESP_FAULT_BIT = 1;                // SLVERR and DECERR both set it

    // Line request from the cache
    typedef struct packed {
        logic                  valid;
        logic                  write;
        logic                  cached;
        logic                  path;    // 0 = data, 1 = instruction
        logic [ADDR_BITS-1:0]  addr;
        logic [LINE_BYTES-1:0] strob;
        logic [LINE_BITS-1:0]  data;
    } mem_req_t;

    // Single-cycle answer to the cache
    typedef struct packed {
        logic                 valid;
        logic                 path;
        logic [LINE_BITS-1:0] data;
        logic                 load_fault;
        logic                 store_fault;
    } mem_resp_t;

    // Shared by AR and AW
    typedef struct packed {
        logic [ADDR_BITS-1:0] addr;
        logic [2:0]           size;
        logic [3:0]           cache;
        logic [2:0]           prot;
    } axi_addr_t;

    typedef struct packed {
        logic [LINE_BITS-1:0]  data;
        logic [LINE_BYTES-1:0] strb;
    } axi_wr_t;

    typedef struct packed {
        logic                 valid;
        logic [LINE_BITS-1:0] data;
        logic                 fault;
    } rd_resp_t;

    typedef struct packed {
        logic valid;
        logic fault;
    } wr_resp_t;

    typedef enum logic [1:0] {rd_idle, rd_addr, rd_data} rd_state_e;
    typedef enum logic [1:0] {wr_idle, wr_addr, wr_data, wr_resp} wr_state_e;
    typedef enum logic {disp_idle, disp_busy} disp_state_e;

endpackage

`default_nettype wire

// ==== src/l1_req_dispatch.sv ====
/*
 * Takes one cache line request at a time, latches it together with its
 * AXI attributes and kicks the read or write sequencer. The sequencer
 * result is folded back into the cache response in the same cycle.
 */
`timescale 1ns/100ps
`default_nettype none

module l1_req_dispatch (
    input  wire                     i_clk,
    input  wire                     i_nrst,
    input  wire l1_axi_pkg::mem_req_t i_req,
    input  wire l1_axi_pkg::rd_resp_t i_rd_resp,
    input  wire l1_axi_pkg::wr_resp_t i_wr_resp,
    output logic                    o_req_ready,
    output logic                    o_rd_go,
    output logic                    o_wr_go,
    output l1_axi_pkg::axi_addr_t   o_addr,
    output l1_axi_pkg::axi_wr_t     o_wdata,
    output l1_axi_pkg::mem_resp_t   o_resp
);

    l1_axi_pkg::disp_state_e state_q;
    l1_axi_pkg::axi_addr_t   addr_q;
    l1_axi_pkg::axi_wr_t     wdata_q;
    logic                    path_q;
    logic                    rd_go_q;
    logic                    wr_go_q;
    logic                    accept;
    logic                    done;

    assign o_req_ready = (state_q == l1_axi_pkg::disp_idle);
    assign accept      = i_req.valid && o_req_ready;
    assign done        = i_rd_resp.valid || i_wr_resp.valid;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state_q <= l1_axi_pkg::disp_idle;
            rd_go_q <= 1'b0;
            wr_go_q <= 1'b0;
        end else begin
            rd_go_q <= accept && !i_req.write;   // One-cycle kick
            wr_go_q <= accept && i_req.write;
            case (state_q)
                l1_axi_pkg::disp_idle: begin
                    if (accept) begin
                        state_q <= l1_axi_pkg::disp_busy;
                    end
                end
                l1_axi_pkg::disp_busy: begin
                    if (done) begin
                        state_q <= l1_axi_pkg::disp_idle;   // Ready again next cycle
                    end
                end
                default: state_q <= l1_axi_pkg::disp_idle;
            endcase
        end
    end

    // Request payload, held stable while the sequencer runs
    always_ff @(posedge i_clk) begin
        if (accept) begin
            path_q      <= i_req.path;
            addr_q.addr <= i_req.addr;
            addr_q.size <= l1_axi_pkg::SIZE_LINE;
            addr_q.cache <= i_req.cached ? l1_axi_pkg::CACHE_WB_ALLOC
                                         : l1_axi_pkg::CACHE_DEVICE;
            addr_q.prot <= {i_req.path, 2'b00};   // Instruction flag, secure, unprivileged
            if (i_req.write) begin
                wdata_q.data <= i_req.data;
                wdata_q.strb <= i_req.strob;
            end else begin
                wdata_q <= '0;
            end
        end
    end

    assign o_rd_go = rd_go_q;
    assign o_wr_go = wr_go_q;
    assign o_addr  = addr_q;
    assign o_wdata = wdata_q;

    // Response pulse follows the sequencer handshake directly
    always_comb begin
        o_resp.valid       = (state_q == l1_axi_pkg::disp_busy) && done;
        o_resp.path        = path_q;
        o_resp.data        = i_rd_resp.data;
        o_resp.load_fault  = i_rd_resp.valid && i_rd_resp.fault;
        o_resp.store_fault = i_wr_resp.valid && i_wr_resp.fault;
    end

endmodule

`default_nettype wire

// ==== tests/axi_mem_model.sv ====
/*
 * AXI4 slave model for the bridge testbench. Holds 32 lines indexed by
 * addr[9:5], adds 0 to 3 cycles of random ready delay on every channel and
 * answers SLVERR from 0xF000_0000 up without touching memory.
 */
`timescale 1ns/100ps
`default_nettype none

module axi_mem_model (
    input  wire                              i_clk,
    input  wire                              i_ar_valid,
    input  wire l1_axi_pkg::axi_addr_t       i_ar,
    output logic                             o_ar_ready,
    input  wire                              i_r_ready,
    output logic                             o_r_valid,
    output logic                             o_r_last,
    output logic [l1_axi_pkg::LINE_BITS-1:0] o_r_data,
    output logic [1:0]                       o_r_resp,
    input  wire                              i_aw_valid,
    input  wire l1_axi_pkg::axi_addr_t       i_aw,
    output logic                             o_aw_ready,
    input  wire                              i_w_valid,
    input  wire                              i_w_last,
    input  wire l1_axi_pkg::axi_wr_t         i_w,
    output logic                             o_w_ready,
    input  wire                              i_b_ready,
    output logic                             o_b_valid,
    output logic [1:0]                       o_b_resp,
    output l1_axi_pkg::axi_addr_t            o_last_ar,
    output l1_axi_pkg::axi_addr_t            o_last_aw
);

    logic [l1_axi_pkg::LINE_BITS-1:0] mem [32];

    function automatic logic in_fault_window(input logic [31:0] addr);
        return addr >= 32'hF000_0000;
    endfunction

    // Bridge outputs come from flops, so the falling edge sees them settled
    initial begin : read_port
        int n;
        o_ar_ready = 1'b0;
        o_r_valid  = 1'b0;
        o_r_last   = 1'b0;
        o_r_data   = '0;
        o_r_resp   = 2'b00;
        o_last_ar  = '0;
        forever begin
            @(negedge i_clk);
            if (i_ar_valid) begin
                repeat ($urandom % 4) @(negedge i_clk);
                o_ar_ready = 1'b1;
                o_last_ar  = i_ar;
                @(negedge i_clk);
                o_ar_ready = 1'b0;
                repeat ($urandom % 4) @(negedge i_clk);
                o_r_valid = 1'b1;
                o_r_last  = 1'b1;   // Single beat
                o_r_data  = in_fault_window(o_last_ar.addr) ? '0 : mem[o_last_ar.addr[9:5]];
                o_r_resp  = in_fault_window(o_last_ar.addr) ? 2'b10 : 2'b00;
                for (n = 0; n < 200 && !i_r_ready; n++) @(negedge i_clk);
                @(negedge i_clk);
                o_r_valid = 1'b0;
                o_r_last  = 1'b0;
            end
        end
    end

    initial begin : write_port
        int n;
        int w_delay;
        logic [5:0] b;
        logic w_taken;
        l1_axi_pkg::axi_wr_t beat;
        for (b = 6'd0; b < 6'd32; b++) begin
            mem[b[4:0]] = '0;
        end
        o_aw_ready = 1'b0;
        o_w_ready  = 1'b0;
        o_b_valid  = 1'b0;
        o_b_resp   = 2'b00;
        o_last_aw  = '0;
        forever begin
            @(negedge i_clk);
            if (i_aw_valid) begin
                repeat ($urandom % 4) @(negedge i_clk);
                o_aw_ready = 1'b1;
                o_last_aw  = i_aw;
                w_delay    = $urandom % 4;
                repeat (w_delay) begin
                    @(negedge i_clk);
                    o_aw_ready = 1'b0;
                end
                o_w_ready = 1'b1;   // Same cycle as aw_ready or later
                beat      = i_w;
                w_taken   = i_w_valid && i_w_last;   // Beat only counts with valid
                @(negedge i_clk);
                o_aw_ready = 1'b0;
                o_w_ready  = 1'b0;
                if (w_taken && !in_fault_window(o_last_aw.addr)) begin
                    for (b = 6'd0; b < 6'd32; b++) begin
                        if (beat.strb[b[4:0]]) begin
                            mem[o_last_aw.addr[9:5]][{b[4:0], 3'b000} +: 8] =
                                beat.data[{b[4:0], 3'b000} +: 8];
                        end
                    end
                end
                repeat ($urandom % 4) @(negedge i_clk);
                o_b_valid = 1'b1;
                o_b_resp  = in_fault_window(o_last_aw.addr) ? 2'b10 : 2'b00;
                for (n = 0; n < 200 && !i_b_ready; n++) @(negedge i_clk);
                @(negedge i_clk);
                o_b_valid = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_l1_axi_bridge.sv ====
/*
 * Testbench for the L1 to AXI bridge. Applies a table of line reads and
 * writes through the AXI memory model and checks data, faults, the
 * one-pulse response and the AR/AW attributes.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_l1_axi_bridge;

    typedef struct {
        string                             name;
        logic                              write;
        logic                              cached;
        logic                              path;
        logic [l1_axi_pkg::ADDR_BITS-1:0]  addr;
        logic [l1_axi_pkg::LINE_BYTES-1:0] strob;
        logic [l1_axi_pkg::LINE_BITS-1:0]  data;
        logic [l1_axi_pkg::LINE_BITS-1:0]  exp_data;
        logic                              exp_lf;
        logic                              exp_sf;
    } vector_t;

    localparam int NUM_ROWS = 8;
    localparam logic [255:0] LINE_A = {4{64'h0123_4567_89AB_CDEF}};
    localparam logic [255:0] LINE_B = {8{32'hDEAD_BEEF}};
    localparam logic [31:0]  PART_STRB = 32'h0000_F00F;   // Bytes 0-3 and 12-15

    logic                  clk = 1'b0;
    logic                  nrst;
    l1_axi_pkg::mem_req_t  req;
    l1_axi_pkg::mem_resp_t resp;
    logic                  req_ready;
    logic                  ar_valid, ar_ready, r_ready, r_valid, r_last;
    logic                  aw_valid, aw_ready, w_valid, w_last, w_ready;
    logic                  b_ready, b_valid;
    logic [255:0]          r_data;
    logic [1:0]            r_resp, b_resp;
    l1_axi_pkg::axi_addr_t ar, aw, last_ar, last_aw;
    l1_axi_pkg::axi_wr_t   w;
    vector_t               vectors [NUM_ROWS];

    always #4 clk = ~clk;

    l1_axi_bridge l1_axi_bridge_inst (
        .i_clk(clk), .i_nrst(nrst), .i_req(req), .o_req_ready(req_ready), .o_resp(resp),
        .o_ar_valid(ar_valid), .o_ar(ar), .i_ar_ready(ar_ready), .o_r_ready(r_ready),
        .i_r_valid(r_valid), .i_r_last(r_last), .i_r_data(r_data), .i_r_resp(r_resp),
        .o_aw_valid(aw_valid), .o_aw(aw), .i_aw_ready(aw_ready), .o_w_valid(w_valid),
        .o_w_last(w_last), .o_w(w), .i_w_ready(w_ready), .o_b_ready(b_ready),
        .i_b_valid(b_valid), .i_b_resp(b_resp)
    );

    axi_mem_model mem_model_inst (
        .i_clk(clk), .i_ar_valid(ar_valid), .i_ar(ar), .o_ar_ready(ar_ready),
        .i_r_ready(r_ready), .o_r_valid(r_valid), .o_r_last(r_last), .o_r_data(r_data),
        .o_r_resp(r_resp), .i_aw_valid(aw_valid), .i_aw(aw), .o_aw_ready(aw_ready),
        .i_w_valid(w_valid), .i_w_last(w_last), .i_w(w), .o_w_ready(w_ready),
        .i_b_ready(b_ready), .o_b_valid(b_valid), .o_b_resp(b_resp), .o_last_ar(last_ar),
        .o_last_aw(last_aw)
    );

    // Old line with the strobed bytes of the new one
    function automatic logic [255:0] merge_bytes(input logic [255:0] old_line,
                                                 input logic [255:0] new_line,
                                                 input logic [31:0] strb);
        logic [255:0] line;
        logic [5:0]   b;
        line = old_line;
        for (b = 6'd0; b < 6'd32; b++) begin
            if (strb[b[4:0]]) begin
                line[{b[4:0], 3'b000} +: 8] = new_line[{b[4:0], 3'b000} +: 8];
            end
        end
        return line;
    endfunction

    task automatic check_value(input string what, input logic [255:0] expected,
                               input logic [255:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s expected %0h actual %0h", what, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "Value mismatch in %s", what);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out after 200 cycles waiting for %s", what);
        $display("Simulation FAILED");
        $fatal(1, "Wait for %s expired", what);
    endtask

    task automatic load_vectors();
        vectors[0] = '{"wr_full", 1'b1, 1'b1, 1'b0, 32'h0000_0100, '1, LINE_A,
                       256'd0, 1'b0, 1'b0};
        vectors[1] = '{"rd_full", 1'b0, 1'b1, 1'b1, 32'h0000_0100, '0, 256'd0,
                       LINE_A, 1'b0, 1'b0};
        vectors[2] = '{"wr_part", 1'b1, 1'b0, 1'b0, 32'h0000_0100, PART_STRB, LINE_B,
                       256'd0, 1'b0, 1'b0};
        vectors[3] = '{"rd_part", 1'b0, 1'b0, 1'b0, 32'h0000_0100, '0, 256'd0,
                       merge_bytes(LINE_A, LINE_B, PART_STRB), 1'b0, 1'b0};
        vectors[4] = '{"rd_untouched", 1'b0, 1'b1, 1'b1, 32'h0000_03E0, '0, 256'd0,
                       256'd0, 1'b0, 1'b0};
        vectors[5] = '{"rd_fault", 1'b0, 1'b0, 1'b0, 32'hF000_0040, '0, 256'd0,
                       256'd0, 1'b1, 1'b0};
        vectors[6] = '{"wr_fault", 1'b1, 1'b1, 1'b1, 32'hF000_0000, '1, LINE_B,
                       256'd0, 1'b0, 1'b1};
        // Same line index as the faulted write, must still read zero
        vectors[7] = '{"rd_line0", 1'b0, 1'b1, 1'b0, 32'h0000_0000, '0, 256'd0,
                       256'd0, 1'b0, 1'b0};
    endtask

    task automatic apply_row(input vector_t v);
        int n;
        l1_axi_pkg::axi_addr_t seen;
        n = 0;
        @(negedge clk);
        while (!req_ready && n < 200) begin   // Registered, stable at the falling edge
            @(negedge clk);
            n++;
        end
        if (!req_ready) begin
            report_timeout("o_req_ready");
        end
        req.valid  = 1'b1;
        req.write  = v.write;
        req.cached = v.cached;
        req.path   = v.path;
        req.addr   = v.addr;
        req.strob  = v.strob;
        req.data   = v.data;
        @(negedge clk);
        req = '0;
        n = 0;
        #1;   // Past the model's falling-edge updates
        while (!resp.valid && n < 200) begin
            check_value({v.name, " ready while busy"}, 256'd0, 256'(req_ready));
            @(negedge clk);
            #1;
            n++;
        end
        if (!resp.valid) begin
            report_timeout("o_resp.valid");
        end
        check_value({v.name, " ready at response"}, 256'd0, 256'(req_ready));
        check_value({v.name, " path"}, 256'(v.path), 256'(resp.path));
        check_value({v.name, " load fault"}, 256'(v.exp_lf), 256'(resp.load_fault));
        check_value({v.name, " store fault"}, 256'(v.exp_sf), 256'(resp.store_fault));
        if (!v.write && !v.exp_lf) begin
            check_value({v.name, " data"}, v.exp_data, resp.data);
        end
        @(negedge clk);
        #1;
        check_value({v.name, " single pulse"}, 256'd0, 256'(resp.valid));
        check_value({v.name, " ready again"}, 256'd1, 256'(req_ready));
        seen = v.write ? last_aw : last_ar;
        check_value({v.name, " addr"}, 256'(v.addr), 256'(seen.addr));
        check_value({v.name, " size"}, 256'(l1_axi_pkg::SIZE_LINE), 256'(seen.size));
        check_value({v.name, " cache"},
                    256'(v.cached ? l1_axi_pkg::CACHE_WB_ALLOC : l1_axi_pkg::CACHE_DEVICE),
                    256'(seen.cache));
        check_value({v.name, " prot"}, 256'({v.path, 2'b00}), 256'(seen.prot));
    endtask

    initial begin : main
        int r;
        void'($urandom(61));
        nrst = 1'b0;
        req  = '0;
        load_vectors();
        repeat (3) @(negedge clk);
        nrst = 1'b1;
        #1;
        check_value("reset req_ready", 256'd1, 256'(req_ready));
        check_value("reset ar_valid", 256'd0, 256'(ar_valid));
        check_value("reset aw_valid", 256'd0, 256'(aw_valid));
        check_value("reset w_valid", 256'd0, 256'(w_valid));
        check_value("reset r_ready", 256'd0, 256'(r_ready));
        check_value("reset b_ready", 256'd0, 256'(b_ready));
        check_value("reset resp valid", 256'd0, 256'(resp.valid));
        for (r = 0; r < NUM_ROWS; r++) begin
            apply_row(vectors[r]);
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire
